/* include/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Sizes in bytes, line widths in bits
`define ICACHE_SIZE       16384
`define ICACHE_SET_ASSOC  2
`define ICACHE_LINE_WIDTH 256

`define DCACHE_SIZE       8192
`define DCACHE_SET_ASSOC  2
`define DCACHE_LINE_WIDTH 256

`endif

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ns --top-module tb_mmu_cp0 \
	-f sim.f -o tb_mmu_cp0 > build.log 2>&1 || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/tb_mmu_cp0 > sim.log 2>&1 || echo "Simulation exited with a nonzero status" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && { echo "Simulation reported a failure"; exit 1; }
grep -q "TEST PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0

/* sim.f */
+incdir+include
verilog/cpu_pkg.sv
verilog/cp0_write_mask.sv
verilog/cp0.sv
verilog/tlb_write_port.sv
verilog/tlb_slot.sv
verilog/tlb_lookup.sv
verilog/mmu_cp0_top.sv
verif/tb_mmu_cp0.sv

/* verif/tb_mmu_cp0.sv */
`timescale 1ns/1ns

module tb_mmu_cp0;

localparam int TLB_ENTRIES = 8;

typedef enum logic [3:0] {
	OP_WRITE, OP_CHECK, OP_BIT, OP_ASID, OP_EXC, OP_ERET, OP_TLBWI, OP_TLBWR,
	OP_TLBP, OP_TLBR, OP_ARM_TIMER, OP_WAIT_TIMER
} op_t;

// For OP_EXC, data carries the pc
typedef struct packed {
	op_t                op;
	logic [3:0]         test;
	logic [2:0]         sel;
	cpu_pkg::reg_addr_t addr;
	cpu_pkg::uint32_t   data;
	cpu_pkg::uint32_t   expected;
	logic               ds;
	logic [4:0]         code;
	cpu_pkg::uint32_t   extra;
} step_t;

logic                 clk, rst;
cpu_pkg::reg_addr_t   raddr;
logic [2:0]           rsel;
cpu_pkg::cp0_req_t    wreq;
cpu_pkg::except_req_t except_req;
logic                 tlbwi_req, tlbwr_req, tlbp_req, tlbr_req;
cpu_pkg::uint32_t     rdata;
logic [7:0]           asid;
logic                 user_mode, kseg0_uncached, timer_int;

step_t            steps[$];
logic [3:0]       cur_test, prev_test;
cpu_pkg::uint32_t lcg_state = 32'h964e_e923;
int               checks, errors, test_errs;

mmu_cp0_top #(.TLB_ENTRIES(TLB_ENTRIES)) mmu_cp0_top_inst (.*);

always #2 clk = ~clk;

function automatic cpu_pkg::uint32_t lcg_next();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state;
endfunction

function automatic cpu_pkg::uint32_t entry_hi_key(input logic [18:0] vpn2, input logic [7:0] id);
	return {vpn2, 5'b0, id};
endfunction

function automatic string test_name(input logic [3:0] n);
	case (n)
		4'd1: return "reset values and masked writes";
		4'd2: return "TLBWI and TLBR round trip";
		4'd3: return "TLBP";
		4'd4: return "TLBWR";
		4'd5: return "exceptions and ERET";
		default: return "Compare timer";
	endcase
endfunction

task automatic push_step(input op_t op, input logic [2:0] sel, input cpu_pkg::reg_addr_t addr,
	input cpu_pkg::uint32_t data, input cpu_pkg::uint32_t expected);
	step_t s;
	s = '0;
	s.op = op;
	s.test = cur_test;
	s.sel = sel;
	s.addr = addr;
	s.data = data;
	s.expected = expected;
	steps.push_back(s);
endtask

task automatic raise_exception(input logic [4:0] code, input logic ds,
	input cpu_pkg::uint32_t pc, input cpu_pkg::uint32_t extra);
	step_t s;
	s = '0;
	s.op = OP_EXC;
	s.test = cur_test;
	s.code = code;
	s.ds = ds;
	s.data = pc;
	s.extra = extra;
	steps.push_back(s);
endtask

task automatic load_tlb_slot(input cpu_pkg::uint32_t slot, input logic [18:0] vpn2,
	input logic [7:0] id, input logic g);
	push_step(OP_WRITE, 3'd0, 5'd10, entry_hi_key(vpn2, id), '0);
	push_step(OP_WRITE, 3'd0, 5'd2, {24'h0, 7'h20, g}, '0);
	push_step(OP_WRITE, 3'd0, 5'd0, slot, '0);
	push_step(OP_TLBWI, 3'd0, 5'd0, '0, '0);
endtask

task automatic probe_expect(input logic [18:0] vpn2, input logic [7:0] id,
	input cpu_pkg::uint32_t index);
	push_step(OP_WRITE, 3'd0, 5'd10, entry_hi_key(vpn2, id), '0);
	push_step(OP_TLBP, 3'd0, 5'd0, '0, '0);
	push_step(OP_CHECK, 3'd0, 5'd0, '0, index);
endtask

task automatic idle_inputs();
	raddr = '0;
	rsel = '0;
	wreq = '0;
	except_req = '0;
	tlbwi_req = 1'b0;
	tlbwr_req = 1'b0;
	tlbp_req = 1'b0;
	tlbr_req = 1'b0;
endtask

task automatic check_word(input cpu_pkg::uint32_t got, input cpu_pkg::uint32_t exp,
	input string what);
	checks++;
	if (got !== exp) begin
		$display("ERR %0t: %s read %h, expected %h", $time, what, got, exp);
		errors++;
		test_errs++;
	end
endtask

task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
	checks++;
	if (got !== exp) begin
		$display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
		errors++;
		test_errs++;
	end
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
	checks++;
	if (got !== exp) begin
		$display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
		errors++;
		test_errs++;
	end
endtask

task automatic report_test(input logic [3:0] n);
	if (test_errs == 0)
		$display("Test %0d %s: ok", n, test_name(n));
	else
		$display("Test %0d %s: %0d errors", n, test_name(n), test_errs);
endtask

task automatic apply_step(input step_t s);
	cpu_pkg::uint32_t count_now;
	int waited;
	@(negedge clk);
	idle_inputs();
	case (s.op)
		OP_WRITE: begin
			wreq.we = 1'b1;
			wreq.wsel = s.sel;
			wreq.waddr = s.addr;
			wreq.wdata = s.data;
		end
		OP_CHECK: begin
			raddr = s.addr;
			rsel = s.sel;
			#1;
			check_word(rdata, s.expected, $sformatf("reg %0d sel %0d", s.addr, s.sel));
		end
		OP_BIT: begin
			#1;
			case (s.addr)
				5'd0: check_bit(user_mode, s.expected[0], "user_mode");
				5'd1: check_bit(kseg0_uncached, s.expected[0], "kseg0_uncached");
				default: check_bit(timer_int, s.expected[0], "timer_int");
			endcase
		end
		OP_ASID: begin
			#1;
			check_byte(asid, s.expected[7:0], "asid");
		end
		OP_EXC: begin
			except_req.valid = 1'b1;
			except_req.delayslot = s.ds;
			except_req.pc = s.data;
			except_req.code = s.code;
			except_req.extra = s.extra;
		end
		OP_ERET: begin
			except_req.valid = 1'b1;
			except_req.eret = 1'b1;
		end
		OP_TLBWI: tlbwi_req = 1'b1;
		OP_TLBWR: tlbwr_req = 1'b1;
		OP_TLBP:  tlbp_req = 1'b1;
		OP_TLBR:  tlbr_req = 1'b1;
		OP_ARM_TIMER: begin
			raddr = 5'd9;
			#1;
			count_now = rdata;
			wreq.we = 1'b1;
			wreq.waddr = 5'd11;
			wreq.wdata = count_now + s.data;
		end
		default: begin
			waited = 0;
			while (timer_int !== 1'b1 && waited < 200) begin
				@(negedge clk);
				waited++;
			end
			checks++;
			if (timer_int !== 1'b1) begin
				$display("Timer interrupt did not rise within 200 cycles");
				errors++;
				test_errs++;
			end
		end
	endcase
endtask

initial begin
	cpu_pkg::uint32_t eh, lo0, lo1, bad_addr, wr_slot;
	clk = 1'b0;
	rst = 1'b1;
	idle_inputs();

	cur_test = 4'd1;
	push_step(OP_CHECK, 3'd0, 5'd12, '0, 32'h1040_0000);
	push_step(OP_CHECK, 3'd1, 5'd15, '0, 32'h8000_0000);
	push_step(OP_CHECK, 3'd0, 5'd15, '0, 32'h0001_8000);
	push_step(OP_CHECK, 3'd0, 5'd1, '0, 32'(TLB_ENTRIES - 1));
	push_step(OP_WRITE, 3'd0, 5'd13, 32'hffff_ffff, '0);
	push_step(OP_CHECK, 3'd0, 5'd13, '0, 32'h0000_0300);
	push_step(OP_WRITE, 3'd0, 5'd15, 32'hffff_ffff, '0);
	push_step(OP_CHECK, 3'd0, 5'd15, '0, 32'h0001_8000);
	push_step(OP_WRITE, 3'd0, 5'd10, 32'hffff_ffff, '0);
	push_step(OP_CHECK, 3'd0, 5'd10, '0, 32'hffff_e0ff);
	push_step(OP_ASID, 3'd0, 5'd0, '0, 32'h0000_00ff);
	push_step(OP_WRITE, 3'd0, 5'd12, 32'h1040_0010, '0);
	push_step(OP_BIT, 3'd0, 5'd0, '0, 32'd1);
	push_step(OP_WRITE, 3'd0, 5'd12, 32'h1040_0000, '0);
	push_step(OP_BIT, 3'd0, 5'd0, '0, 32'd0);
	push_step(OP_WRITE, 3'd0, 5'd16, 32'd2, '0);
	push_step(OP_BIT, 3'd0, 5'd1, '0, 32'd1);
	push_step(OP_WRITE, 3'd0, 5'd16, 32'd3, '0);
	push_step(OP_BIT, 3'd0, 5'd1, '0, 32'd0);
	push_step(OP_WRITE, 3'd1, 5'd15, 32'hffff_ffff, '0);
	push_step(OP_CHECK, 3'd1, 5'd15, '0, 32'hbfff_f000);

	// Top bit set keeps this vpn2 clear of the probe keys below
	cur_test = 4'd2;
	eh = lcg_next() | 32'h8000_0000;
	lo0 = lcg_next();
	lo1 = lcg_next();
	push_step(OP_WRITE, 3'd0, 5'd10, eh, '0);
	push_step(OP_WRITE, 3'd0, 5'd2, lo0, '0);
	push_step(OP_WRITE, 3'd0, 5'd3, lo1, '0);
	push_step(OP_WRITE, 3'd0, 5'd0, 32'd2, '0);
	push_step(OP_TLBWI, 3'd0, 5'd0, '0, '0);
	push_step(OP_WRITE, 3'd0, 5'd10, '0, '0);
	push_step(OP_WRITE, 3'd0, 5'd2, '0, '0);
	push_step(OP_WRITE, 3'd0, 5'd3, '0, '0);
	push_step(OP_WRITE, 3'd0, 5'd0, 32'd2, '0);
	push_step(OP_TLBR, 3'd0, 5'd0, '0, '0);
	push_step(OP_CHECK, 3'd0, 5'd10, '0, eh & 32'hffff_e0ff);
	push_step(OP_CHECK, 3'd0, 5'd2, '0, lo0 & 32'h3fff_ffff);
	push_step(OP_CHECK, 3'd0, 5'd3, '0, (lo1 & 32'h3fff_fffe) | {31'b0, lo0[0]});

	cur_test = 4'd3;
	load_tlb_slot(32'd0, 19'h101, 8'h11, 1'b0);
	load_tlb_slot(32'd1, 19'h102, 8'h22, 1'b1);
	load_tlb_slot(32'd3, 19'h103, 8'h33, 1'b0);
	probe_expect(19'h103, 8'h33, 32'd3);
	probe_expect(19'h101, 8'h11, 32'd0);
	probe_expect(19'h101, 8'h55, 32'h8000_0000);
	probe_expect(19'h102, 8'h55, 32'd1);
	probe_expect(19'h1ff, 8'h11, 32'h8000_0000);

	// No TLBWR before this point, so Random still holds its reset value
	cur_test = 4'd4;
	wr_slot = 32'(TLB_ENTRIES - 1);
	push_step(OP_WRITE, 3'd0, 5'd10, entry_hi_key(19'h104, 8'h44), '0);
	push_step(OP_WRITE, 3'd0, 5'd2, 32'h0000_0080, '0);
	push_step(OP_CHECK, 3'd0, 5'd1, '0, wr_slot);
	push_step(OP_TLBWR, 3'd0, 5'd0, '0, '0);
	push_step(OP_TLBP, 3'd0, 5'd0, '0, '0);
	push_step(OP_CHECK, 3'd0, 5'd0, '0, wr_slot);
	push_step(OP_CHECK, 3'd0, 5'd1, '0, (wr_slot + 32'd1) % 32'(TLB_ENTRIES));

	cur_test = 4'd5;
	bad_addr = 32'h7fff_a123;
	push_step(OP_WRITE, 3'd0, 5'd13, '0, '0);
	push_step(OP_WRITE, 3'd0, 5'd10, 32'h0000_0012, '0);
	push_step(OP_WRITE, 3'd0, 5'd4, 32'h1234_5678, '0);
	push_step(OP_CHECK, 3'd0, 5'd4, '0, 32'h1200_0000);
	raise_exception(cpu_pkg::EXCCODE_TLBL, 1'b1, 32'h8000_1004, bad_addr);
	push_step(OP_CHECK, 3'd0, 5'd14, '0, 32'h8000_1000);
	push_step(OP_CHECK, 3'd0, 5'd13, '0, {1'b1, 24'b0, cpu_pkg::EXCCODE_TLBL, 2'b0});
	push_step(OP_CHECK, 3'd0, 5'd12, '0, 32'h1040_0002);
	push_step(OP_CHECK, 3'd0, 5'd8, '0, bad_addr);
	push_step(OP_CHECK, 3'd0, 5'd4, '0, 32'h1200_0000 | {9'b0, bad_addr[31:13], 4'b0});
	push_step(OP_CHECK, 3'd0, 5'd10, '0, {bad_addr[31:13], 13'h0012});
	// Nested entry keeps EPC and bd
	raise_exception(cpu_pkg::EXCCODE_ADEL, 1'b0, 32'h8000_2000, 32'h0000_0abc);
	push_step(OP_CHECK, 3'd0, 5'd14, '0, 32'h8000_1000);
	push_step(OP_CHECK, 3'd0, 5'd13, '0, {1'b1, 24'b0, cpu_pkg::EXCCODE_ADEL, 2'b0});
	push_step(OP_CHECK, 3'd0, 5'd8, '0, 32'h0000_0abc);
	raise_exception(cpu_pkg::EXCCODE_INT, 1'b0, 32'h8000_3000, 32'h0000_0084);
	push_step(OP_CHECK, 3'd0, 5'd13, '0, 32'h8000_8400);
	push_step(OP_ERET, 3'd0, 5'd0, '0, '0);
	push_step(OP_CHECK, 3'd0, 5'd12, '0, 32'h1040_0000);

	cur_test = 4'd6;
	push_step(OP_ARM_TIMER, 3'd0, 5'd11, 32'd20, '0);
	push_step(OP_WAIT_TIMER, 3'd0, 5'd0, '0, '0);
	push_step(OP_BIT, 3'd0, 5'd2, '0, 32'd1);
	push_step(OP_WRITE, 3'd0, 5'd11, '0, '0);
	push_step(OP_BIT, 3'd0, 5'd2, '0, 32'd0);

	repeat (4) @(posedge clk);
	@(negedge clk);
	rst = 1'b0;

	prev_test = steps[0].test;
	for (int i = 0; i < steps.size(); i++) begin
		if (steps[i].test != prev_test) begin
			report_test(prev_test);
			prev_test = steps[i].test;
			test_errs = 0;
		end
		apply_step(steps[i]);
	end
	report_test(prev_test);
	@(negedge clk);
	idle_inputs();

	$display("Checks: %0d, errors: %0d", checks, errors);
	if (errors == 0)
		$display("TEST PASSED");
	else
		$display("TEST FAILED");
	$finish;
end

endmodule

/* verilog/cp0.sv */
`timescale 1ns/1ns
`include "cpu_defs.svh"

module cp0 #(
	parameter int TLB_ENTRIES = 8
) (
	input  logic                         clk,
	input  logic                         rst,
	input  cpu_pkg::reg_addr_t           raddr,
	input  logic [2:0]                   rsel,
	input  cpu_pkg::cp0_req_t            wreq,
	input  cpu_pkg::except_req_t         except_req,
	input  logic                         tlbr_req,
	input  cpu_pkg::tlb_entry_t          tlbr_res,
	input  logic                         tlbp_req,
	input  cpu_pkg::uint32_t             tlbp_res,
	input  logic                         tlbwr_req,
	output cpu_pkg::tlb_entry_t          tlb_wdata,
	output logic [$clog2(TLB_ENTRIES)-1:0] tlb_index,
	output logic [$clog2(TLB_ENTRIES)-1:0] tlb_random,
	output cpu_pkg::uint32_t             rdata,
	output logic [7:0]                   asid,
	output logic                         user_mode,
	output logic                         kseg0_uncached,
	output logic                         timer_int
);

localparam int IDX_W = $clog2(TLB_ENTRIES);
localparam cpu_pkg::uint32_t RANDOM_MAX = TLB_ENTRIES - 1;

// M set, standard TLB, K0 cacheable
localparam cpu_pkg::uint32_t CONFIG0_VALUE = {1'b1, 21'b0, 3'd1, 4'b0, 3'd3};
localparam cpu_pkg::uint32_t PRID_VALUE = {8'h00, 8'h01, 16'h8000};

localparam int MMU_SIZE = TLB_ENTRIES - 1;
localparam int IC_SETS = $clog2(`ICACHE_SIZE * 8 / `ICACHE_SET_ASSOC / `ICACHE_LINE_WIDTH / 64);
localparam int IC_LINE = $clog2(`ICACHE_LINE_WIDTH / 32) + 1;
localparam int IC_ASSOC = `ICACHE_SET_ASSOC - 1;
localparam int DC_SETS = $clog2(`DCACHE_SIZE * 8 / `DCACHE_SET_ASSOC / `DCACHE_LINE_WIDTH / 64);
localparam int DC_LINE = $clog2(`DCACHE_LINE_WIDTH / 32) + 1;
localparam int DC_ASSOC = `DCACHE_SET_ASSOC - 1;

cpu_pkg::cp0_regfile_u rf, rf_nxt, rf_init;
cpu_pkg::uint32_t      ebase, config1, wmask;
logic                  compare_we, ebase_we;

assign config1 = {
	1'b0,
	MMU_SIZE[5:0],
	IC_SETS[2:0], IC_LINE[2:0], IC_ASSOC[2:0],
	DC_SETS[2:0], DC_LINE[2:0], DC_ASSOC[2:0],
	7'd0
};

assign asid           = rf.named.entry_hi[7:0];
assign user_mode      = rf.named.status.um & ~rf.named.status.exl & ~rf.named.status.erl;
assign kseg0_uncached = (rf.named.config0[2:0] == 3'd2);
assign tlb_index      = rf.named.index[IDX_W-1:0];
assign tlb_random     = rf.named.random[IDX_W-1:0];

// Entry for TLBWI/TLBWR, also the TLBP key
assign tlb_wdata.vpn2 = rf.named.entry_hi[31:13];
assign tlb_wdata.asid = rf.named.entry_hi[7:0];
assign tlb_wdata.pfn0 = rf.named.entry_lo0[29:6];
assign tlb_wdata.c0   = rf.named.entry_lo0[5:3];
assign tlb_wdata.d0   = rf.named.entry_lo0[2];
assign tlb_wdata.v0   = rf.named.entry_lo0[1];
assign tlb_wdata.pfn1 = rf.named.entry_lo1[29:6];
assign tlb_wdata.c1   = rf.named.entry_lo1[5:3];
assign tlb_wdata.d1   = rf.named.entry_lo1[2];
assign tlb_wdata.v1   = rf.named.entry_lo1[1];
assign tlb_wdata.g    = rf.named.entry_lo0[0];

assign compare_we = wreq.we && wreq.wsel == 3'd0 && wreq.waddr == 5'd11;
assign ebase_we   = wreq.we && wreq.wsel == 3'd1 && wreq.waddr == 5'd15;

cp0_write_mask cp0_write_mask_inst (
	.sel  (wreq.wsel),
	.addr (wreq.waddr),
	.mask (wmask)
);

always_comb begin
	rdata = '0;
	if (rsel == 3'd0) begin
		rdata = rf.words[raddr];
	end else if (rsel == 3'd1) begin
		case (raddr)
			5'd15: rdata = ebase;
			5'd16: rdata = config1;
			default: rdata = '0;
		endcase
	end
end

always_comb begin
	rf_init = '0;
	rf_init.named.random  = RANDOM_MAX;
	rf_init.named.status  = 32'h1040_0000;
	rf_init.named.prid    = PRID_VALUE;
	rf_init.named.config0 = CONFIG0_VALUE;
end

always_comb begin
	rf_nxt = rf;
	rf_nxt.named.count = rf.named.count + 32'd1;
	if (tlbwr_req)
		rf_nxt.named.random = (rf.named.random == RANDOM_MAX) ? '0 : rf.named.random + 32'd1;

	if (wreq.we && wreq.wsel == 3'd0)
		rf_nxt.words[wreq.waddr] = (wreq.wdata & wmask) | (rf_nxt.words[wreq.waddr] & ~wmask);

	if (tlbr_req) begin
		rf_nxt.named.entry_hi[31:13] = tlbr_res.vpn2;
		rf_nxt.named.entry_hi[7:0]   = tlbr_res.asid;
		rf_nxt.named.entry_lo0 = {2'b0, tlbr_res.pfn0, tlbr_res.c0,
			tlbr_res.d0, tlbr_res.v0, tlbr_res.g};
		rf_nxt.named.entry_lo1 = {2'b0, tlbr_res.pfn1, tlbr_res.c1,
			tlbr_res.d1, tlbr_res.v1, tlbr_res.g};
	end

	if (tlbp_req)
		rf_nxt.named.index = tlbp_res;

	if (except_req.valid) begin
		if (except_req.eret) begin
			if (rf_nxt.named.status.erl)
				rf_nxt.named.status.erl = 1'b0;
			else
				rf_nxt.named.status.exl = 1'b0;
		end else begin
			// Nested exceptions keep the first EPC
			if (!rf_nxt.named.status.exl) begin
				rf_nxt.named.epc = except_req.delayslot ? except_req.pc - 32'd4 : except_req.pc;
				rf_nxt.named.cause.bd = except_req.delayslot;
			end
			rf_nxt.named.status.exl = 1'b1;
			rf_nxt.named.cause.exc_code = except_req.code;

			if (except_req.code == cpu_pkg::EXCCODE_INT)
				rf_nxt.named.cause.ip = except_req.extra[7:0];

			if (except_req.code == cpu_pkg::EXCCODE_ADEL ||
				except_req.code == cpu_pkg::EXCCODE_ADES) begin
				rf_nxt.named.bad_vaddr = except_req.extra;
			end else if (except_req.code == cpu_pkg::EXCCODE_TLBL ||
				except_req.code == cpu_pkg::EXCCODE_TLBS) begin
				rf_nxt.named.bad_vaddr = except_req.extra;
				// Context bad_vpn2 and EntryHi vpn2 for the refill handler
				rf_nxt.named.context_[22:4]  = except_req.extra[31:13];
				rf_nxt.named.entry_hi[31:13] = except_req.extra[31:13];
			end
		end
	end
end

always_ff @(posedge clk) begin
	if (rst) begin
		rf <= rf_init;
		ebase <= 32'h8000_0000;
	end else begin
		rf <= rf_nxt;
		if (ebase_we)
			ebase[29:12] <= wreq.wdata[29:12];
	end
end

// Held until software rewrites Compare
always_ff @(posedge clk) begin
	if (rst)
		timer_int <= 1'b0;
	else if (compare_we)
		timer_int <= 1'b0;
	else if (rf.named.compare != '0 && rf.named.compare == rf.named.count)
		timer_int <= 1'b1;
end

assert property (@(posedge clk) disable iff (rst) rf.named.random < TLB_ENTRIES)
	else $error("Random left the TLB range");

assert property (@(posedge clk) disable iff (rst)
	(except_req.valid && except_req.eret) |-> !(tlbr_req || tlbp_req || tlbwr_req))
	else $error("ERET issued together with a TLB instruction");

endmodule

/* verilog/cp0_write_mask.sv */
`timescale 1ns/1ns

module cp0_write_mask (
	input  logic [2:0]         sel,
	input  cpu_pkg::reg_addr_t addr,
	output cpu_pkg::uint32_t   mask
);

always_comb begin
	mask = '0;
	if (sel == 3'd0) begin
		case (addr)
			5'd0:  mask = 32'h0000_001f;
			5'd2:  mask = 32'h3fff_ffff;
			5'd3:  mask = 32'h3fff_ffff;
			// PTEBase only
			5'd4:  mask = 32'hff80_0000;
			5'd6:  mask = 32'h0000_001f;
			5'd9:  mask = 32'hffff_ffff;
			// vpn2 and asid
			5'd10: mask = 32'hffff_e0ff;
			5'd11: mask = 32'hffff_ffff;
			// cu0, bev, im, um, erl, exl, ie
			5'd12: mask = 32'h1040_ff17;
			// Software interrupt bits
			5'd13: mask = 32'h0000_0300;
			5'd14: mask = 32'hffff_ffff;
			// K0
			5'd16: mask = 32'h0000_0007;
			default: mask = '0;
		endcase
	end
end

endmodule

/* verilog/cpu_pkg.sv */
package cpu_pkg;

typedef logic [31:0] uint32_t;
typedef logic [4:0]  reg_addr_t;

// CP0 register 12
typedef struct packed {
	logic [3:0] cu;
	logic [4:0] rsvd_27_23;
	logic       bev;
	logic [5:0] rsvd_21_16;
	logic [7:0] im;
	logic [2:0] rsvd_7_5;
	logic       um;
	logic       rsvd_3;
	logic       erl;
	logic       exl;
	logic       ie;
} status_t;

// CP0 register 13
typedef struct packed {
	logic        bd;
	logic [14:0] rsvd_30_16;
	logic [7:0]  ip;
	logic        rsvd_7;
	logic [4:0]  exc_code;
	logic [1:0]  rsvd_1_0;
} cause_t;

// Highest register first, so register 0 sits in the low word
typedef struct packed {
	uint32_t        rsvd_31;
	uint32_t        error_epc;
	uint32_t [12:0] rsvd_29_17;
	uint32_t        config0;
	uint32_t        prid;
	uint32_t        epc;
	cause_t         cause;
	status_t        status;
	uint32_t        compare;
	uint32_t        entry_hi;
	uint32_t        count;
	uint32_t        bad_vaddr;
	uint32_t        rsvd_7;
	uint32_t        wired;
	uint32_t        page_mask;
	uint32_t        context_;
	uint32_t        entry_lo1;
	uint32_t        entry_lo0;
	uint32_t        random;
	uint32_t        index;
} cp0_named_t;

typedef union packed {
	uint32_t [31:0] words;
	cp0_named_t     named;
} cp0_regfile_u;

typedef struct packed {
	logic      we;
	logic [2:0] wsel;
	reg_addr_t waddr;
	uint32_t   wdata;
} cp0_req_t;

typedef struct packed {
	logic       valid;
	logic       eret;
	logic       delayslot;
	uint32_t    pc;
	logic [4:0] code;
	// Bad address, or pending interrupt lines for EXCCODE_INT
	uint32_t    extra;
} except_req_t;

typedef struct packed {
	logic [18:0] vpn2;
	logic [7:0]  asid;
	logic [23:0] pfn0;
	logic [2:0]  c0;
	logic        d0;
	logic        v0;
	logic [23:0] pfn1;
	logic [2:0]  c1;
	logic        d1;
	logic        v1;
	logic        g;
} tlb_entry_t;

localparam logic [4:0] EXCCODE_INT  = 5'd0;
localparam logic [4:0] EXCCODE_TLBL = 5'd2;
localparam logic [4:0] EXCCODE_TLBS = 5'd3;
localparam logic [4:0] EXCCODE_ADEL = 5'd4;
localparam logic [4:0] EXCCODE_ADES = 5'd5;

endpackage

/* verilog/mmu_cp0_top.sv */
`timescale 1ns/1ns

module mmu_cp0_top #(
	parameter int TLB_ENTRIES = 8
) (
	input  logic                 clk,
	input  logic                 rst,
	input  cpu_pkg::reg_addr_t   raddr,
	input  logic [2:0]           rsel,
	input  cpu_pkg::cp0_req_t    wreq,
	input  cpu_pkg::except_req_t except_req,
	input  logic                 tlbwi_req,
	input  logic                 tlbwr_req,
	input  logic                 tlbp_req,
	input  logic                 tlbr_req,
	output cpu_pkg::uint32_t     rdata,
	output logic [7:0]           asid,
	output logic                 user_mode,
	output logic                 kseg0_uncached,
	output logic                 timer_int
);

localparam int IDX_W = $clog2(TLB_ENTRIES);

cpu_pkg::tlb_entry_t    tlb_wdata, tlbr_res;
cpu_pkg::tlb_entry_t    entries [TLB_ENTRIES];
cpu_pkg::uint32_t       tlbp_res;
logic [IDX_W-1:0]       tlb_index, tlb_random;
logic [TLB_ENTRIES-1:0] slot_we, hits;

cp0 #(
	.TLB_ENTRIES (TLB_ENTRIES)
) cp0_inst (
	.clk,
	.rst,
	.raddr,
	.rsel,
	.wreq,
	.except_req,
	.tlbr_req,
	.tlbr_res,
	.tlbp_req,
	.tlbp_res,
	.tlbwr_req,
	.tlb_wdata,
	.tlb_index,
	.tlb_random,
	.rdata,
	.asid,
	.user_mode,
	.kseg0_uncached,
	.timer_int
);

tlb_write_port #(
	.TLB_ENTRIES (TLB_ENTRIES)
) tlb_write_port_inst (
	.clk,
	.tlbwi_req,
	.tlbwr_req,
	.tlb_index,
	.tlb_random,
	.slot_we
);

for (genvar i = 0; i < TLB_ENTRIES; i++) begin : g_slot
	tlb_slot tlb_slot_inst (
		.clk,
		.rst,
		.we         (slot_we[i]),
		.wdata      (tlb_wdata),
		.probe_vpn2 (tlb_wdata.vpn2),
		.probe_asid (tlb_wdata.asid),
		.entry      (entries[i]),
		.hit        (hits[i])
	);
end

tlb_lookup #(
	.TLB_ENTRIES (TLB_ENTRIES)
) tlb_lookup_inst (
	.entries,
	.hits,
	.tlb_index,
	.tlbp_res,
	.tlbr_res
);

endmodule

/* verilog/tlb_lookup.sv */
`timescale 1ns/1ns

module tlb_lookup #(
	parameter int TLB_ENTRIES = 8
) (
	input  cpu_pkg::tlb_entry_t            entries [TLB_ENTRIES],
	input  logic [TLB_ENTRIES-1:0]         hits,
	input  logic [$clog2(TLB_ENTRIES)-1:0] tlb_index,
	output cpu_pkg::uint32_t               tlbp_res,
	output cpu_pkg::tlb_entry_t            tlbr_res
);

// P bit alone on a miss, else the lowest hitting slot
always_comb begin
	tlbp_res = 32'h8000_0000;
	for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
		if (hits[i])
			tlbp_res = i;
	end
end

assign tlbr_res = entries[tlb_index];

always_comb begin
	if (!$isunknown(hits))
		assert final ($onehot0(hits))
			else $error("Probe key matches more than one TLB entry");
end

endmodule

/* verilog/tlb_slot.sv */
`timescale 1ns/1ns

module tlb_slot (
	input  logic                clk,
	input  logic                rst,
	input  logic                we,
	input  cpu_pkg::tlb_entry_t wdata,
	input  logic [18:0]         probe_vpn2,
	input  logic [7:0]          probe_asid,
	output cpu_pkg::tlb_entry_t entry,
	output logic                hit
);

logic valid;

always_ff @(posedge clk) begin
	if (rst)
		valid <= 1'b0;
	else if (we)
		valid <= 1'b1;
end

always_ff @(posedge clk) begin
	if (we)
		entry <= wdata;
end

// Global entries ignore the ASID
assign hit = valid && entry.vpn2 == probe_vpn2 && (entry.g || entry.asid == probe_asid);

endmodule

/* verilog/tlb_write_port.sv */
`timescale 1ns/1ns

module tlb_write_port #(
	parameter int TLB_ENTRIES = 8
) (
	input  logic                           clk,
	input  logic                           tlbwi_req,
	input  logic                           tlbwr_req,
	input  logic [$clog2(TLB_ENTRIES)-1:0] tlb_index,
	input  logic [$clog2(TLB_ENTRIES)-1:0] tlb_random,
	output logic [TLB_ENTRIES-1:0]         slot_we
);

localparam int IDX_W = $clog2(TLB_ENTRIES);

logic [IDX_W-1:0] slot_idx;

// TLBWR targets the Random slot, TLBWI the Index slot
assign slot_idx = tlbwr_req ? tlb_random : tlb_index;

always_comb begin
	slot_we = '0;
	if (tlbwi_req || tlbwr_req)
		slot_we[slot_idx] = 1'b1;
end

assert property (@(posedge clk) !(tlbwi_req && tlbwr_req))
	else $error("TLBWI and TLBWR issued in the same cycle");

endmodule
